// ==== doppler_ctrl.f ====
+incdir+include
hw/spi_link_pkg.sv
hw/led_drive_pkg.sv
hw/spi_frame_slave.sv
hw/led_matrix_scan.sv
hw/saw_ramp.sv
hw/pdm_modulator.sv
hw/doppler_ctrl_top.sv
dv/doppler_ctrl_tb.sv

// ==== Makefile ====
TOP = doppler_ctrl_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timescale 1ns/100ps --top-module doppler_ctrl_top \
	  hw/spi_link_pkg.sv hw/led_drive_pkg.sv hw/spi_frame_slave.sv \
	  hw/led_matrix_scan.sv hw/saw_ramp.sv hw/pdm_modulator.sv \
	  hw/doppler_ctrl_top.sv

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f doppler_ctrl.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== include/spi_host_tasks.svh ====
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// host side of the frame port, included inside the testbench module
// drives cfg_cs, cfg_sck, cfg_si and samples cfg_so of the enclosing scope

// wait n rising clk edges, then step to the drive point just after the edge
task automatic host_wait(input int n);
  repeat (n) @(posedge clk);
  #0.5;
endtask

// lines at rest, chip deselected
task automatic host_idle();
  cfg_cs  = 1'b1;
  cfg_sck = 1'b0;
  cfg_si  = 1'b0;
endtask

// send tx MSB first and capture the return bits into rx
// each return bit is taken just before the rising sck that shifts it away
task automatic host_frame(input  spi_link_pkg::frame_t tx,
                          output spi_link_pkg::frame_t rx);
  rx = '1;
  host_wait(1);
  cfg_cs = 1'b0;
  host_wait(spi_link_pkg::HOST_HOLD_CLKS); // slave loads the pin snapshot here
  for (int i = spi_link_pkg::FRAME_BITS - 1; i >= 0; i--) begin
    cfg_sck = 1'b0;
    cfg_si  = tx[i];
    host_wait(spi_link_pkg::HOST_HOLD_CLKS);
    rx[i]   = cfg_so;
    cfg_sck = 1'b1;
    host_wait(spi_link_pkg::HOST_HOLD_CLKS);
  end
  cfg_sck = 1'b0;
  host_wait(spi_link_pkg::HOST_HOLD_CLKS);
  cfg_cs = 1'b1;                           // commit to the led word
  host_wait(spi_link_pkg::HOST_HOLD_CLKS);
endtask

`endif

// ==== dv/doppler_ctrl_tb.sv ====
`timescale 1ns/100ps

module doppler_ctrl_tb;

  localparam int CLK_HALF_NS     = 2;
  localparam int RESET_CYCLES    = 10;
  localparam int MATRIX_CELLS    = led_drive_pkg::MATRIX_ROWS * led_drive_pkg::MATRIX_COLS;
  localparam int MIN_SCAN_CYCLES = MATRIX_CELLS * led_drive_pkg::SCAN_STEP_CYCLES;
  localparam int HOLD_CYCLES     = 64;
  localparam int FADE_WINDOW     = 1024 * led_drive_pkg::RAMP_STEP_CYCLES;
  localparam int FADE_TOL        = 4;
  localparam int WATCHDOG_NS     = 200000;

  logic                                  clk = 1'b0;
  logic                                  rst;
  logic                                  cfg_cs;
  logic                                  cfg_sck;
  logic                                  cfg_si;
  logic                                  pdm_hold;
  spi_link_pkg::frame_t                  pin_in;
  logic                                  cfg_so;
  logic                                  pdm_led;
  logic [led_drive_pkg::MATRIX_COLS-1:0] aled;
  logic [led_drive_pkg::MATRIX_ROWS-1:0] kled_tri;

  int                      err_cnt  = 0;
  int                      test_cnt = 0;
  int                      run_cyc;      // clocks since reset release
  logic                    scan_chk_en;  // word on display is known
  spi_link_pkg::frame_t    exp_word;

  `include "spi_host_tasks.svh"

  always #CLK_HALF_NS clk = ~clk;

  doppler_ctrl_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .cfg_cs   (cfg_cs),
    .cfg_sck  (cfg_sck),
    .cfg_si   (cfg_si),
    .pdm_hold (pdm_hold),
    .pin_in   (pin_in),
    .cfg_so   (cfg_so),
    .pdm_led  (pdm_led),
    .aled     (aled),
    .kled_tri (kled_tri)
  );

  always @(posedge clk) begin
    if (rst)
      run_cyc <= 0;
    else
      run_cyc <= run_cyc + 1;
  end

  // expected position counts from reset release and the outputs lag it by one clock
  always @(posedge clk) begin : scan_check
    led_drive_pkg::scan_idx_t              pos;
    int                                    row;
    int                                    col;
    logic [led_drive_pkg::MATRIX_COLS-1:0] exp_aled;
    logic [led_drive_pkg::MATRIX_ROWS-1:0] exp_kled;
    if (!rst && scan_chk_en && run_cyc > 0) begin
      pos = led_drive_pkg::scan_idx_t'((run_cyc - 1) / led_drive_pkg::SCAN_STEP_CYCLES);
      row = int'(pos) / led_drive_pkg::MATRIX_COLS;
      col = int'(pos) % led_drive_pkg::MATRIX_COLS;
      exp_aled = ~(led_drive_pkg::MATRIX_COLS'(1) << col);
      exp_kled = exp_word[pos] ? (led_drive_pkg::MATRIX_ROWS'(1) << row) : '0;
      assert (aled == exp_aled) else begin
        err_cnt++;
        $display("[FAIL] aled at position %0d: expected 0x%h, got 0x%h", pos, exp_aled, aled);
      end
      assert (kled_tri == exp_kled) else begin
        err_cnt++;
        $display("[FAIL] kled_tri at position %0d: expected 0x%h, got 0x%h",
                 pos, exp_kled, kled_tri);
      end
    end
  end

  // indicator stays dark from the clock after hold is seen
  a_hold_dark : assert property (
    @(posedge clk) disable iff (rst) $past(pdm_hold) |-> !pdm_led
  ) else begin
    err_cnt++;
    $display("[FAIL] pdm_led: expected 0x0, got 0x%h while held", $sampled(pdm_led));
  end

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      err_cnt++;
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic run_frame(input  spi_link_pkg::frame_t word,
                           input  spi_link_pkg::frame_t pins,
                           output spi_link_pkg::frame_t rx);
    scan_chk_en = 1'b0;  // display is in flux until the commit
    pin_in      = pins;
    host_frame(word, rx);
    exp_word    = word;
  endtask

  // one full scan pass over all matrix positions
  task automatic check_display();
    scan_chk_en = 1'b1;
    for (int n = 0; n < MIN_SCAN_CYCLES; n++)
      host_wait(1);
    scan_chk_en = 1'b0;
  endtask

  // every amplitude appears RAMP_STEP_CYCLES times in one ramp period
  function automatic int fade_expected_ones();
    longint ramp_sum;
    ramp_sum = 0;
    for (int a = 0; a <= int'(led_drive_pkg::AMP_MAX); a++)
      ramp_sum += longint'(a) * led_drive_pkg::RAMP_STEP_CYCLES;
    return int'(ramp_sum / longint'(led_drive_pkg::AMP_MAX));
  endfunction

  task automatic check_fade();
    int held_ones;
    int ones;
    int exp_ones;
    int diff;
    pdm_hold  = 1'b1;
    held_ones = 0;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      host_wait(1);
      if (pdm_led)
        held_ones++;
    end
    check_equal("pdm_led ones while held", held_ones, 0);
    pdm_hold = 1'b0;
    ones     = 0;
    for (int i = 0; i < FADE_WINDOW; i++) begin
      host_wait(1);
      if (pdm_led)
        ones++;
    end
    exp_ones = fade_expected_ones();
    diff     = ones - exp_ones;
    if (diff < 0)
      diff = -diff;
    assert (diff <= FADE_TOL) else begin
      err_cnt++;
      $display("[FAIL] pdm_led ones: expected 0x%h +/- %0d, got 0x%h", exp_ones, FADE_TOL, ones);
    end
  endtask

  initial begin : main
    spi_link_pkg::frame_t word;
    spi_link_pkg::frame_t pins;
    spi_link_pkg::frame_t rx;
    int                   errs_before;
    void'($urandom(32'ha90ba5e7));
    rst         = 1'b1;
    pdm_hold    = 1'b0;
    pin_in      = '0;
    scan_chk_en = 1'b0;
    exp_word    = '0;
    host_idle();
    host_wait(RESET_CYCLES);
    rst = 1'b0;

    errs_before = err_cnt;
    check_equal("cfg_so", 32'(cfg_so), 32'h1);
    check_equal("kled_tri", 32'(kled_tri), 32'h0);
    check_equal("pdm_led", 32'(pdm_led), 32'h0);
    assert ($countones(~aled) == 1) else begin
      err_cnt++;
      $display("aled does not have exactly one low bit after reset (0x%h)", aled);
    end
    report_test("reset_state", errs_before);

    errs_before = err_cnt;
    word = spi_link_pkg::frame_t'($urandom);
    pins = spi_link_pkg::frame_t'($urandom);
    run_frame(word, pins, rx);
    check_display();
    report_test("matrix_display", errs_before);

    errs_before = err_cnt;
    pins = spi_link_pkg::frame_t'($urandom);
    run_frame(word, pins, rx);
    check_equal("cfg_so return word", 32'(rx), 32'(pins));
    report_test("pin_readback", errs_before);

    errs_before = err_cnt;
    word = word ^ (spi_link_pkg::frame_t'($urandom) | 16'h0001); // always a new word
    pins = spi_link_pkg::frame_t'($urandom);
    run_frame(word, pins, rx);
    check_equal("cfg_so return word", 32'(rx), 32'(pins));
    check_display();
    report_test("overwrite", errs_before);

    errs_before = err_cnt;
    check_fade();
    report_test("fade_output", errs_before);

    $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== hw/doppler_ctrl_top.sv ====
`timescale 1ns/100ps

module doppler_ctrl_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  cfg_cs,
  input  logic                                  cfg_sck,
  input  logic                                  cfg_si,
  input  logic                                  pdm_hold,
  input  spi_link_pkg::frame_t                  pin_in,
  output logic                                  cfg_so,
  output logic                                  pdm_led,
  output logic [led_drive_pkg::MATRIX_COLS-1:0] aled,
  output logic [led_drive_pkg::MATRIX_ROWS-1:0] kled_tri
);

  spi_link_pkg::frame_t led_bits;  // committed host word
  led_drive_pkg::amp_t  ramp_amp;

  spi_frame_slave i_spi (
    .clk      (clk),
    .rst      (rst),
    .cfg_cs   (cfg_cs),
    .cfg_sck  (cfg_sck),
    .cfg_si   (cfg_si),
    .pin_in   (pin_in),
    .cfg_so   (cfg_so),
    .led_bits (led_bits)
  );

  led_matrix_scan i_scan (
    .clk      (clk),
    .rst      (rst),
    .led_bits (led_bits),
    .aled     (aled),
    .kled_tri (kled_tri)
  );

  // fade path for the indicator output
  saw_ramp i_ramp (
    .clk (clk),
    .rst (rst),
    .amp (ramp_amp)
  );

  pdm_modulator i_pdm (
    .clk  (clk),
    .rst  (rst),
    .hold (pdm_hold),
    .din  (ramp_amp),
    .dout (pdm_led)
  );

endmodule

// ==== hw/pdm_modulator.sv ====
`timescale 1ns/100ps

module pdm_modulator (
  input  logic                clk,
  input  logic                rst,
  input  logic                hold,
  input  led_drive_pkg::amp_t din,
  output logic                dout
);

  led_drive_pkg::amp_t din_q;  // input register
  led_drive_pkg::amp_t err;    // running quantization error

  always_ff @(posedge clk) begin
    if (rst)
      din_q <= '0;
    else
      din_q <= din;
  end

  // first order error feedback that keeps err within 0..AMP_MAX
  always_ff @(posedge clk) begin
    if (rst || hold) begin
      dout <= 1'b0;
      err  <= '0;
    end else if (din_q >= err) begin
      dout <= 1'b1;
      err  <= err + (led_drive_pkg::AMP_MAX - din_q);
    end else begin
      dout <= 1'b0;
      err  <= err - din_q;
    end
  end

  // the indicator goes dark the cycle after hold
  a_hold_dark : assert property (
    @(posedge clk) disable iff (rst) hold |=> !dout
  );

endmodule

// ==== hw/saw_ramp.sv ====
`timescale 1ns/100ps

module saw_ramp (
  input  logic                clk,
  input  logic                rst,
  output led_drive_pkg::amp_t amp
);

  logic [led_drive_pkg::RAMP_DIV_BITS-1:0] div_cnt;
  logic                                    step;

  assign step = (div_cnt == led_drive_pkg::RAMP_DIV_BITS'(led_drive_pkg::RAMP_STEP_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
      amp     <= led_drive_pkg::AMP_MAX; // start at full scale
    end else begin
      div_cnt <= step ? '0 : div_cnt + 1'b1;
      if (step) begin
        // falling edge of the saw, jump back up after zero
        if (amp == '0)
          amp <= led_drive_pkg::AMP_MAX;
        else
          amp <= amp - 1'b1;
      end
    end
  end

endmodule

// ==== hw/led_matrix_scan.sv ====
`timescale 1ns/100ps

module led_matrix_scan (
  input  logic                                    clk,
  input  logic                                    rst,
  input  spi_link_pkg::frame_t                    led_bits,
  output logic [led_drive_pkg::MATRIX_COLS-1:0]   aled,     // active low column select
  output logic [led_drive_pkg::MATRIX_ROWS-1:0]   kled_tri  // one-hot row enable or all off
);

  logic [led_drive_pkg::SCAN_DIV_BITS-1:0] step_cnt;
  led_drive_pkg::scan_idx_t                pos;

  logic [led_drive_pkg::ROW_BITS-1:0]    row_sel;
  logic [led_drive_pkg::COL_BITS-1:0]    col_sel;
  logic [led_drive_pkg::MATRIX_ROWS-1:0] row_hot;
  logic [led_drive_pkg::MATRIX_COLS-1:0] col_hot;

  // step divider and position index starting at 0
  always_ff @(posedge clk) begin
    if (rst) begin
      step_cnt <= '0;
      pos      <= '0;
    end else if (step_cnt ==
                 led_drive_pkg::SCAN_DIV_BITS'(led_drive_pkg::SCAN_STEP_CYCLES - 1)) begin
      step_cnt <= '0;
      pos      <= pos + 1'b1; // wraps after the last position
    end else begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  // row = pos / cols and col = pos % cols
  assign col_sel = pos[led_drive_pkg::COL_BITS-1:0];
  assign row_sel = pos[led_drive_pkg::COL_BITS +: led_drive_pkg::ROW_BITS];

  always_comb begin
    row_hot          = '0;
    col_hot          = '0;
    row_hot[row_sel] = 1'b1;
    col_hot[col_sel] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      aled     <= ~led_drive_pkg::MATRIX_COLS'(1); // column 0
      kled_tri <= '0;
    end else begin
      aled     <= ~col_hot;
      kled_tri <= led_bits[pos] ? row_hot : '0; // dark positions leave all rows off
    end
  end

  a_aled_one_low : assert property (
    @(posedge clk) disable iff (rst) $onehot(~aled)
  );

  a_kled_onehot0 : assert property (
    @(posedge clk) disable iff (rst) $onehot0(kled_tri)
  );

endmodule

// ==== hw/spi_frame_slave.sv ====
`timescale 1ns/100ps

module spi_frame_slave (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cfg_cs,
  input  logic                 cfg_sck,
  input  logic                 cfg_si,
  input  spi_link_pkg::frame_t pin_in,
  output logic                 cfg_so,
  output spi_link_pkg::frame_t led_bits
);

  // two-flop synchronizers, bit 0 is the first stage
  logic [1:0] cs_sync;
  logic [1:0] sck_sync;
  logic [1:0] si_sync;

  logic cs_rise;
  logic cs_fall;
  logic sck_rise;
  logic frame_active;

  spi_link_pkg::frame_t shift_in;   // incoming word, MSB first
  spi_link_pkg::frame_t shift_out;  // pin readback

  always_ff @(posedge clk) begin
    if (rst) begin
      cs_sync  <= 2'b11; // idle deselected, no false edge out of reset
      sck_sync <= 2'b00;
      si_sync  <= 2'b00;
    end else begin
      cs_sync  <= {cs_sync[0], cfg_cs};
      sck_sync <= {sck_sync[0], cfg_sck};
      si_sync  <= {si_sync[0], cfg_si};
    end
  end

  assign cs_rise      = cs_sync[0] & ~cs_sync[1];
  assign cs_fall      = ~cs_sync[0] & cs_sync[1];
  assign sck_rise     = sck_sync[0] & ~sck_sync[1];
  assign frame_active = ~cs_sync[1];

  // shift-in side, committed to the led word when cs goes high
  always_ff @(posedge clk) begin
    if (rst) begin
      shift_in <= '0;
      led_bits <= '0;
    end else if (cs_rise) begin
      led_bits <= shift_in;
    end else if (sck_rise && frame_active) begin
      shift_in <= {shift_in[spi_link_pkg::FRAME_BITS-2:0], si_sync[1]};
    end
  end

  // readback side
  // snapshot at frame start, then one bit per sck rise with ones behind it
  always_ff @(posedge clk) begin
    if (rst) begin
      shift_out <= '1;
    end else if (cs_fall) begin
      shift_out <= pin_in;
    end else if (sck_rise && frame_active) begin
      shift_out <= {shift_out[spi_link_pkg::FRAME_BITS-2:0], 1'b1};
    end
  end

  assign cfg_so = shift_out[spi_link_pkg::FRAME_BITS-1]; // next return bit

  a_cs_edges_exclusive : assert property (
    @(posedge clk) disable iff (rst) !(cs_rise && cs_fall)
  );

endmodule

// ==== hw/led_drive_pkg.sv ====
package led_drive_pkg;

  // 4x4 matrix, position index = row * MATRIX_COLS + col
  localparam int MATRIX_ROWS = 4;
  localparam int MATRIX_COLS = 4;
  localparam int ROW_BITS    = $clog2(MATRIX_ROWS);
  localparam int COL_BITS    = $clog2(MATRIX_COLS);

  typedef logic [ROW_BITS+COL_BITS-1:0] scan_idx_t;

  localparam int SCAN_STEP_CYCLES = 32;                      // clocks per lit position
  localparam int SCAN_DIV_BITS    = $clog2(SCAN_STEP_CYCLES);

  // fade generator
  localparam int AMP_BITS = 10;

  typedef logic [AMP_BITS-1:0] amp_t;

  localparam amp_t AMP_MAX = amp_t'((1 << AMP_BITS) - 1);   // full scale

  // kept short so a whole ramp period fits in a simulation run
  localparam int RAMP_STEP_CYCLES = 4;
  localparam int RAMP_DIV_BITS    = $clog2(RAMP_STEP_CYCLES);

endpackage

// ==== hw/spi_link_pkg.sv ====
package spi_link_pkg;

  // one host frame, shifted MSB first
  localparam int FRAME_BITS = 16;

  // clk cycles the host holds each sck/si level (slave needs at least 4)
  localparam int HOST_HOLD_CLKS = 8;

  typedef logic [FRAME_BITS-1:0] frame_t; // led word, pin snapshot, shifters

endpackage
